// File: files.f
rv_isa_pkg.sv
mouse_pkg.sv
mouse_alu.sv
mouse_sequencer.sv
mouse_core.sv
tb_mouse_mem.sv
tb_mouse.sv

// File: tb_mouse.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mouse
  import rv_isa_pkg::*;
  import mouse_pkg::*;
();

//////////////////////////////
// run length, expectations
//////////////////////////////

localparam int clk_ns     = 4;
localparam int n_inst     = 16;                        // before the self-loop
localparam int exp_ns     = n_inst * 4 * 3 * clk_ns;  // 4 transfers of 3 cycles
// 2.5x expected rounded up to a whole us
localparam int timeout_ns = ((exp_ns * 5 / 2 + 999) / 1000) * 1000;

localparam int n_fetch = 19;
localparam int n_wr    = 13;
localparam logic [XLEN-1:0] loop_adr = 32'h3c;
localparam logic [XLEN-1:0] st_adr   = 32'h808;       // 0x1004 - 0x7fc
localparam logic [XLEN-1:0] st_dat   = 32'h1234_50f4;  // x10

// 0x2c skipped by JAL, call to 0x40, JALR back to 0x34, then loop at 0x3c
localparam logic [XLEN-1:0] fetch_tbl [n_fetch] = '{
  32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c, 32'h20, 32'h24,
  32'h28, 32'h30, 32'h40, 32'h44, 32'h34, 32'h38, 32'h3c, 32'h3c, 32'h3c};

localparam logic [4:0] wr_reg [n_wr] = '{
  5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd14, 5'd15, 5'd16};

localparam logic [XLEN-1:0] wr_val [n_wr] = '{
  32'h1234_5000,  // lui
  32'h0000_1004,  // auipc at 0x04
  32'hffff_fffb,  // -5
  32'h0000_0007,
  32'hffff_fff4,  // -5 - 7
  32'h0000_0001,  // -5 < 7 signed
  32'h0000_0000,  // not below 7 unsigned
  32'h1234_50ff,  // x1 ^ 0xff
  32'hffff_ffff,  // x8 | x3
  32'h1234_50f4,  // x8 & x5
  32'h0000_0034,  // link of call at 0x30
  32'h0000_0006,  // x4 - 1
  32'h0000_0048}; // link of jalr at 0x44

logic            clk;
logic            rst;
logic            bus_vld;
bus_req_t        bus_req;
logic            bus_rdy;
logic [XLEN-1:0] bus_rdt;

// per test bookkeeping
string    test_name [5] = '{"reset", "back-pressure", "fetch order", "register writes",
                            "store and loop"};
int       n_chk [5];
int       n_err [5];
int       fetch_cnt;
int       wr_cnt;
int       st_cnt;
int       loop_cnt;
int       err_total;
bit       first_done;
bit       hold;      // stalled at previous negedge
bus_req_t held_req;

mouse_core UUT (
  .clk     (clk),
  .rst     (rst),
  .bus_vld (bus_vld),
  .bus_req (bus_req),
  .bus_rdy (bus_rdy),
  .bus_rdt (bus_rdt)
);

tb_mouse_mem mem (
  .clk     (clk),
  .bus_vld (bus_vld),
  .bus_req (bus_req),
  .bus_rdy (bus_rdy),
  .bus_rdt (bus_rdt)
);

//////////////////////////////
// instruction encoders
//////////////////////////////

function automatic inst_u r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, logic [4:0] rd);
  inst_u w;
  w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP, len: 2'b11};
  return w;
endfunction

function automatic inst_u i_type(opc_t op, logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                 logic [11:0] imm);
  inst_u w;
  w.i = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op, len: 2'b11};
  return w;
endfunction

function automatic inst_u s_type(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
  inst_u w;
  w.s = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: fn3_st_w, imm_4_0: imm[4:0],
          opcode: STORE, len: 2'b11};
  return w;
endfunction

function automatic inst_u u_type(opc_t op, logic [4:0] rd, logic [19:0] imm);
  inst_u w;
  w.u = '{imm_31_12: imm, rd: rd, opcode: op, len: 2'b11};
  return w;
endfunction

function automatic inst_u j_type(logic [4:0] rd, logic [20:0] off);
  inst_u w;
  w.j = '{imm_20: off[20], imm_10_1: off[10:1], imm_11: off[11], imm_19_12: off[19:12],
          rd: rd, opcode: JAL, len: 2'b11};
  return w;
endfunction

task automatic load_program();
  inst_u prog [18];
  prog[0]  = u_type(LUI, 5'd1, 20'h12345);
  prog[1]  = u_type(AUIPC, 5'd2, 20'h00001);
  prog[2]  = i_type(OP_IMM, ADD, 5'd3, 5'd0, 12'hffb);   // addi x3, x0, -5
  prog[3]  = i_type(OP_IMM, ADD, 5'd4, 5'd0, 12'h007);
  prog[4]  = r_type(7'h20, 5'd4, 5'd3, ADD, 5'd5);        // sub
  prog[5]  = r_type(7'h00, 5'd4, 5'd3, SLT, 5'd6);
  prog[6]  = r_type(7'h00, 5'd4, 5'd3, SLTU, 5'd7);
  prog[7]  = i_type(OP_IMM, XOR, 5'd8, 5'd1, 12'h0ff);
  prog[8]  = r_type(7'h00, 5'd3, 5'd8, OR, 5'd9);
  prog[9]  = r_type(7'h00, 5'd5, 5'd8, AND, 5'd10);
  prog[10] = j_type(5'd0, 21'd8);                         // over 0x2c
  prog[11] = i_type(OP_IMM, ADD, 5'd12, 5'd0, 12'h066);  // never runs
  prog[12] = j_type(5'd14, 21'h10);                       // call 0x40
  prog[13] = s_type(5'd10, 5'd2, 12'h804);                // sw x10, -0x7fc(x2)
  prog[14] = i_type(OP_IMM, ADD, 5'd0, 5'd4, 12'h009);   // x0 target
  prog[15] = j_type(5'd0, 21'd0);                         // self-loop
  prog[16] = i_type(OP_IMM, ADD, 5'd15, 5'd4, 12'hfff);
  prog[17] = i_type(JALR, 3'b000, 5'd16, 5'd14, 12'h001); // bit 0 cleared
  for (int k = 0; k < 18; k++) begin
    mem.ram[k] = prog[k];
  end
endtask

//////////////////////////////
// checking
//////////////////////////////

task automatic log_error(int t, string msg);
  n_err[t]++;
  $display("FAILED %0t: %s", $time, msg);
endtask

task automatic check_transfer();
  logic [XLEN-1:0] off;
  logic [4:0]      n;
  off = bus_req.adr - GPR_ADR;
  n   = off[6:2];
  if (!first_done) begin
    first_done = 1'b1;
    n_chk[0]++;
    assert (!bus_req.wen && bus_req.adr == RST_ADR)
      else log_error(0, $sformatf("first transfer wen %b adr %h", bus_req.wen, bus_req.adr));
  end
  if (bus_req.adr >= GPR_ADR && off < 32'd128) begin
    if (bus_req.wen) begin
      n_chk[3]++;
      assert (n != 5'd0) else log_error(3, "write transfer at the x0 address");
      if (wr_cnt >= n_wr) begin
        log_error(3, $sformatf("extra register write x%0d = %h", n, bus_req.wdt));
      end else begin
        assert (n == wr_reg[wr_cnt] && bus_req.wdt == wr_val[wr_cnt])
          else log_error(3, $sformatf("wrote x%0d = %h, expected x%0d = %h", n, bus_req.wdt,
                                      wr_reg[wr_cnt], wr_val[wr_cnt]));
      end
      wr_cnt++;
    end
  end else if (bus_req.wen) begin
    n_chk[4]++;
    st_cnt++;
    // word store, all four byte lanes
    assert (st_cnt == 1 && bus_req.adr == st_adr && bus_req.wdt == st_dat &&
            bus_req.ben == 4'hf)
      else log_error(4, $sformatf("store #%0d at %h data %h ben %h", st_cnt, bus_req.adr,
                                  bus_req.wdt, bus_req.ben));
  end else begin
    // only fetches read outside the register block
    n_chk[2]++;
    if (fetch_cnt < n_fetch) begin
      assert (bus_req.adr == fetch_tbl[fetch_cnt])
        else log_error(2, $sformatf("fetch %0d at %h, expected %h", fetch_cnt, bus_req.adr,
                                    fetch_tbl[fetch_cnt]));
    end
    if (bus_req.adr == loop_adr) begin
      loop_cnt++;
    end
    fetch_cnt++;
  end
endtask

// sampled at negedge where the bus is settled for the coming edge
always @(negedge clk) begin
  if (rst) begin
    n_chk[0]++;
    assert (!bus_vld) else log_error(0, "bus_vld high during reset");
  end else begin
    if (hold) begin
      n_chk[1]++;
      assert (bus_req == held_req)
        else log_error(1, $sformatf("request %h became %h while stalled", held_req, bus_req));
    end
    hold     = bus_vld && !bus_rdy;
    held_req = bus_req;
    if (bus_vld && bus_rdy) begin
      check_transfer();
    end
  end
end

task automatic report(output int total);
  int chk;
  chk   = 0;
  total = 0;
  for (int t = 0; t < 5; t++) begin
    $display("test %0d %s: %0d checks, %0d errors", t + 1, test_name[t], n_chk[t], n_err[t]);
    chk   += n_chk[t];
    total += n_err[t];
  end
  $display("total: %0d checks, %0d errors", chk, total);
endtask

//////////////////////////////
// clock, reset, run
//////////////////////////////

initial clk = 1'b0;
always #(clk_ns / 2) clk = ~clk;

initial begin
  rst = 1'b1;
  #1;
  load_program();  // after the memory fill
  repeat (8) @(posedge clk);
  rst <= 1'b0;
  wait (fetch_cnt == n_fetch);
  // closing checks
  n_chk[4] += 3;
  assert (st_cnt == 1) else log_error(4, $sformatf("saw %0d stores, expected one", st_cnt));
  assert (mem.ram[st_adr[11:2]] == st_dat)
    else log_error(4, $sformatf("data word holds %h", mem.ram[st_adr[11:2]]));
  assert (loop_cnt == 3) else log_error(4, $sformatf("self-loop fetched %0d times", loop_cnt));
  n_chk[3]++;
  assert (wr_cnt == n_wr) else log_error(3, $sformatf("%0d register writes seen", wr_cnt));
  report(err_total);
  if (err_total == 0) begin
    $display("ALL CHECKS PASSED");
  end else begin
    $display("CHECKS FAILED");
  end
  $finish;
end

// watchdog
initial begin
  #(timeout_ns);
  $display("timeout after %0d ns, only %0d of %0d fetches seen", timeout_ns, fetch_cnt,
           n_fetch);
  $display("CHECKS FAILED");
  $finish;
end

endmodule

`default_nettype wire

// File: tb_mouse_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mouse_mem
  import mouse_pkg::*;
(
  input  logic            clk,
  // shared memory bus, slave side
  input  logic            bus_vld,
  input  bus_req_t        bus_req,
  output logic            bus_rdy,
  output logic [XLEN-1:0] bus_rdt
);

// 4 KiB, program from 0, data around 0x800, registers from GPR_ADR
localparam int words = 1024;

logic [XLEN-1:0] ram [words];
logic [31:0]     rnd;  // xorshift state for ready

//////////////////////////////
// helpers
//////////////////////////////

function automatic logic [31:0] xorshift(logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

//////////////////////////////
// contents and ready
//////////////////////////////

initial begin
  rnd     = 32'hb0bb;  // fixed seed
  bus_rdy = 1'b0;
  bus_rdt = '0;
  // byte address in the low bits, so every word differs
  for (int i = 0; i < words; i++) begin
    ram[i] = 32'ha5a5_0000 ^ (32'(i) << 2);
  end
  // register block starts cleared, x0 must read zero
  for (int n = 0; n < 32; n++) begin
    ram[(GPR_ADR >> 2) + n] = '0;
  end
end

always @(posedge clk) begin
  rnd     <= xorshift(rnd);
  bus_rdy <= (rnd % 32'd3) != 32'd0;  // about two thirds ready
  if (bus_vld && bus_rdy) begin
    if (bus_req.wen) begin
      ram[bus_req.adr[11:2]] <= bus_req.wdt;
      bus_rdt                <= bus_req.wdt;  // nobody uses it after a write
    end else begin
      bus_rdt <= ram[bus_req.adr[11:2]];  // shows up one transfer late
    end
  end
end

endmodule

`default_nettype wire

// File: mouse_core.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_core
  import mouse_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // shared memory bus
  output logic            bus_vld,
  output bus_req_t        bus_req,
  input  logic            bus_rdy,
  input  logic [XLEN-1:0] bus_rdt
);

//////////////////////////////
// sequencer to alu
//////////////////////////////

alu_req_t        alu_req;
logic [XLEN-1:0] alu_result;  // combinational, same cycle

mouse_sequencer i_seq (
  .clk        (clk),
  .rst        (rst),
  .bus_vld    (bus_vld),
  .bus_req    (bus_req),
  .bus_rdy    (bus_rdy),
  .bus_rdt    (bus_rdt),
  .alu_req    (alu_req),
  .alu_result (alu_result)
);

// arithmetic and address adder
mouse_alu i_alu (
  .alu_req (alu_req),
  .result  (alu_result)
);

endmodule

`default_nettype wire

// File: mouse_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_sequencer
  import rv_isa_pkg::*;
  import mouse_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // shared memory bus
  output logic            bus_vld,
  output bus_req_t        bus_req,
  input  logic            bus_rdy,
  input  logic [XLEN-1:0] bus_rdt,
  // alu
  output alu_req_t        alu_req,
  input  logic [XLEN-1:0] alu_result
);

//////////////////////////////
// helpers
//////////////////////////////

function automatic logic [XLEN-1:0] imm_i(inst_u iw);
  return {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
endfunction

function automatic logic [XLEN-1:0] imm_s(inst_u iw);
  return {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
endfunction

function automatic logic [XLEN-1:0] imm_u(inst_u iw);
  return {iw.u.imm_31_12, 12'd0};
endfunction

function automatic logic [XLEN-1:0] imm_j(inst_u iw);
  return {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12, iw.j.imm_11, iw.j.imm_10_1,
          1'b0};
endfunction

// register N at GPR_ADR + 4*N
function automatic logic [XLEN-1:0] gpr_adr(logic [4:0] idx);
  return GPR_ADR + XLEN'({idx, 2'b00});
endfunction

function automatic bus_req_t gpr_rd(logic [4:0] idx);
  return '{wen: 1'b0, adr: gpr_adr(idx), ben: 4'hf, wdt: '0};
endfunction

// x0 writes go out as reads
function automatic bus_req_t gpr_wr(logic [4:0] idx, logic [XLEN-1:0] dat);
  return '{wen: (idx != 5'd0), adr: gpr_adr(idx), ben: 4'hf, wdt: dat};
endfunction

//////////////////////////////
// state
//////////////////////////////

logic            bus_trn;    // transfer
phase_t          phase;
phase_t          phase_nxt;
logic [XLEN-1:0] pc;         // address of current instruction
inst_u           inw_buf;    // instruction buffer
logic [XLEN-1:0] dat_buf;    // read data from previous phase
inst_u           bus_inst;   // read data as instruction

assign bus_trn  = bus_vld & bus_rdy;
assign bus_inst = bus_rdt;   // valid in phase 1

always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    bus_vld <= 1'b0;
    phase   <= PH0;
    pc      <= RST_ADR;
    inw_buf <= {25'd0, JAL, 2'b11};  // JAL x0, 0 so first fetch hits RST_ADR
  end else begin
    bus_vld <= 1'b1;  // valid for good
    if (bus_trn) begin
      phase <= phase_nxt;
      if (phase == PH0) begin
        pc <= bus_req.adr;  // fetch address becomes pc
      end
      if (phase == PH1) begin
        inw_buf <= bus_inst;
      end
    end
  end
end

// rs1 after phase 2 or 3, later used by JALR fetch
always_ff @(posedge clk) begin
  if (bus_trn && (phase == PH2 || phase == PH3)) begin
    dat_buf <= bus_rdt;
  end
end

//////////////////////////////
// request generation
//////////////////////////////

always_comb begin
  // idle defaults, harmless x0 read
  phase_nxt = PH0;
  bus_req   = gpr_rd(5'd0);
  alu_req   = '{op1: pc, op2: XLEN'(4), fn3: ADD, sub: 1'b0, arith: 1'b0};
  case (phase)
    PH0: begin
      phase_nxt = PH1;
      if (inw_buf.r.opcode == JAL) begin
        alu_req.op2 = imm_j(inw_buf);  // pc + J imm
      end else if (inw_buf.r.opcode == JALR) begin
        alu_req.op1 = dat_buf;  // rs1
        alu_req.op2 = imm_i(inw_buf);
      end
      bus_req.adr = alu_result;  // otherwise pc + 4
      if (inw_buf.r.opcode == JALR) begin
        bus_req.adr[0] = 1'b0;
      end
    end
    PH1: begin
      case (bus_inst.r.opcode)
        LUI: begin
          bus_req = gpr_wr(bus_inst.u.rd, imm_u(bus_inst));
        end
        AUIPC: begin
          alu_req.op2 = imm_u(bus_inst);
          bus_req     = gpr_wr(bus_inst.u.rd, alu_result);
        end
        JAL: begin
          bus_req = gpr_wr(bus_inst.j.rd, alu_result);  // link pc + 4
        end
        JALR, OP_IMM: begin
          phase_nxt = PH3;  // no rs2
          bus_req   = gpr_rd(bus_inst.i.rs1);
        end
        OP, STORE: begin
          phase_nxt = PH2;
          bus_req   = gpr_rd(bus_inst.r.rs1);
        end
        default: begin
          phase_nxt = PH0;  // unsupported retires here
        end
      endcase
    end
    PH2: begin
      phase_nxt = PH3;
      bus_req   = gpr_rd(inw_buf.r.rs2);
    end
    PH3: begin
      case (inw_buf.r.opcode)
        OP: begin
          // rs1 in buffer, rs2 on the bus
          alu_req.op1   = dat_buf;
          alu_req.op2   = bus_rdt;
          alu_req.fn3   = inw_buf.r.funct3;
          alu_req.sub   = inw_buf.r.funct7[5] && (inw_buf.r.funct3 == ADD);
          alu_req.arith = 1'b1;
          bus_req       = gpr_wr(inw_buf.r.rd, alu_result);
        end
        OP_IMM: begin
          alu_req.op1   = bus_rdt;  // rs1 straight off the bus
          alu_req.op2   = imm_i(inw_buf);
          alu_req.fn3   = inw_buf.i.funct3;
          alu_req.arith = 1'b1;
          bus_req       = gpr_wr(inw_buf.i.rd, alu_result);
        end
        JALR: begin
          bus_req = gpr_wr(inw_buf.i.rd, alu_result);  // link pc + 4
        end
        STORE: begin
          alu_req.op1 = dat_buf;
          alu_req.op2 = imm_s(inw_buf);
          bus_req     = '{wen: 1'b1, adr: alu_result, ben: 4'hf, wdt: bus_rdt};
        end
        default: begin
          bus_req = gpr_rd(5'd0);
        end
      endcase
    end
    default: begin
      phase_nxt = PH0;
    end
  endcase
end

//////////////////////////////
// checks
//////////////////////////////

// held read data keeps the request steady
req_hold: assert property (@(posedge clk) disable iff (rst)
  bus_vld && !bus_rdy |=> $stable(bus_req))
  else $error("bus request changed under back-pressure");

vld_hold: assert property (@(posedge clk) disable iff (rst)
  bus_vld |=> bus_vld)
  else $error("bus valid dropped after reset");

opc_known: assert property (@(posedge clk) disable iff (rst)
  bus_trn && phase == PH1 |->
    bus_inst.r.opcode inside {LUI, AUIPC, JAL, JALR, OP_IMM, OP, STORE})
  else $error("unsupported opcode retired as no-op");

endmodule

`default_nettype wire

// File: mouse_alu.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_alu
  import rv_isa_pkg::*;
  import mouse_pkg::*;
(
  input  alu_req_t        alu_req,
  output logic [XLEN-1:0] result
);

logic            cmp;      // SLT or SLTU
logic            add_inv;  // invert op2, carry in
logic [XLEN-1:0] add_op2;
logic [XLEN:0]   add_sum;  // msb is carry out
logic            lt_s;
logic            lt_u;
logic [XLEN-1:0] log_out;

//////////////////////////////
// adder
//////////////////////////////

// compares always subtract
assign cmp     = alu_req.arith & ((alu_req.fn3 == SLT) | (alu_req.fn3 == SLTU));
assign add_inv = alu_req.sub | cmp;
assign add_op2 = alu_req.op2 ^ {XLEN{add_inv}};
assign add_sum = {1'b0, alu_req.op1} + {1'b0, add_op2} + (XLEN+1)'(add_inv);

assign lt_u = ~add_sum[XLEN];  // no carry means borrow
// equal signs use the difference, else op1 sign decides
assign lt_s = (alu_req.op1[XLEN-1] == alu_req.op2[XLEN-1]) ? add_sum[XLEN-1]
                                                            : alu_req.op1[XLEN-1];

//////////////////////////////
// logic unit and select
//////////////////////////////

always_comb begin
  case (alu_req.fn3)
    XOR:     log_out = alu_req.op1 ^ alu_req.op2;
    OR:      log_out = alu_req.op1 | alu_req.op2;
    default: log_out = alu_req.op1 & alu_req.op2;
  endcase
end

always_comb begin
  if (!alu_req.arith) begin
    result = add_sum[XLEN-1:0];  // address work
  end else begin
    case (alu_req.fn3)
      SLT:          result = XLEN'(lt_s);
      SLTU:         result = XLEN'(lt_u);
      XOR, OR, AND: result = log_out;
      default:      result = add_sum[XLEN-1:0];  // ADD, SUB
    endcase
  end
end

// shifts are not built, the sequencer must never ask for one
no_shift: assert final (!(alu_req.arith === 1'b1 &&
                          (alu_req.fn3 === SL || alu_req.fn3 === SR)))
  else $error("shift funct3 requested from the alu");

endmodule

`default_nettype wire

// File: mouse_pkg.sv
`default_nettype none

package mouse_pkg;

  //////////////////////////////
  // address map
  //////////////////////////////

  localparam int unsigned XLEN = 32;

  localparam logic [XLEN-1:0] RST_ADR = 32'h0000_0000;  // first fetch
  localparam logic [XLEN-1:0] GPR_ADR = 32'h0000_0F80;  // x0 lives here, xN at +4*N

  //////////////////////////////
  // sequencer and bus types
  //////////////////////////////

  // one bus transfer per phase
  typedef enum logic [1:0] {
    PH0,  // fetch
    PH1,  // decode, rd write or rs1 read
    PH2,  // rs2 read
    PH3   // rd write or store
  } phase_t;

  // shared memory bus request
  typedef struct packed {
    logic            wen;  // write enable
    logic [XLEN-1:0] adr;  // byte address
    logic [3:0]      ben;  // byte enable, word stores only
    logic [XLEN-1:0] wdt;  // write data
  } bus_req_t;

  // alu request
  typedef struct packed {
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [2:0]      fn3;    // alu funct3
    logic            sub;    // SUB in OP
    logic            arith;  // funct3 result, else plain sum
  } alu_req_t;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  //////////////////////////////
  // base opcodes
  //////////////////////////////

  // instruction bits [6:2]
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,  // recognized only as unsupported
    OP_IMM = 5'b00_100,
    AUIPC  = 5'b00_101,
    STORE  = 5'b01_000,
    OP     = 5'b01_100,
    LUI    = 5'b01_101,
    BRANCH = 5'b11_000,  // recognized only as unsupported
    JALR   = 5'b11_001,
    JAL    = 5'b11_011
  } opc_t;

  // alu funct3 for OP and OP_IMM
  typedef enum logic [2:0] {
    ADD  = 3'b000,  // funct7[5] selects SUB in OP
    SL   = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,
    OR   = 3'b110,
    AND  = 3'b111
  } fn3_alu_t;

  localparam logic [2:0] fn3_st_w = 3'b010;  // SW

  //////////////////////////////
  // instruction formats
  //////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opc_t       opcode;
    logic [1:0] len;     // 2'b11 for 32-bit encodings
  } r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opc_t        opcode;
    logic [1:0]  len;
  } i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opc_t       opcode;
    logic [1:0] len;
  } s_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opc_t        opcode;
    logic [1:0]  len;
  } u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opc_t       opcode;
    logic [1:0] len;
  } j_t;

  // one word, five views
  typedef union packed {
    r_t r;
    i_t i;
    s_t s;
    u_t u;
    j_t j;
  } inst_u;

endpackage

`default_nettype wire
